// File: compile.f
common/icache_pkg.sv
rtl/icache_lookup/icache_way_array.sv
rtl/icache_lookup/icache_fetch_align.sv
rtl/icache_miss/icache_mshr.sv
rtl/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - files:
      - common/icache_pkg.sv
      - rtl/icache_lookup/icache_way_array.sv
      - rtl/icache_lookup/icache_fetch_align.sv
      - rtl/icache_miss/icache_mshr.sv
      - rtl/icache_top.sv
  - target: simulation
    files:
      - testbench/icache_mem_model.sv
      - testbench/icache_tb.sv

// File: testbench/icache_tb.sv
/*
  testbench for the instruction cache
  clock, reset, fetch stimulus, wrong-tag response injection
  immediate assertions, watchdog, closing report
*/

module icache_tb
  import icache_pkg::*;
();

  localparam int FETCH_WIDTH = 4;
  localparam int NUM_SETS    = 32;
  localparam int IDX_W       = $clog2(NUM_SETS);
  localparam int TAG_W       = PC_W - IDX_W - OFFSET_W - INST_BYTES_LOG;
  localparam int IDX_LSB     = OFFSET_W + INST_BYTES_LOG;
  localparam int CLK_PERIOD  = 4;
  localparam int MAX_DELAY   = 9;

  // fetch accesses over all tests, refills included
  localparam int PLANNED_ACCESSES = 80;
  localparam int WATCHDOG_CYCLES  = 40 * PLANNED_ACCESSES + 200;

  logic                              clk;
  logic                              reset;
  logic                              fetch_req;
  logic [PC_W-1:0]                   pc;
  logic [FETCH_WIDTH-1:0][INST_W-1:0] inst;
  logic [FETCH_WIDTH-1:0]            inst_valid;
  logic                              ic_miss;
  logic                              mem_req_valid;
  logic [TAG_W+IDX_W-1:0]            mem_req_addr;
  logic                              flush;
  logic                              flush_done;

  // memory model answer, merged with the injected wrong-tag response
  logic                              model_valid;
  logic [TAG_W-1:0]                  model_tag;
  logic [IDX_W-1:0]                  model_index;
  line_u                             model_data;
  logic                              spur_valid;
  logic [TAG_W-1:0]                  spur_tag;
  logic [IDX_W-1:0]                  spur_index;
  logic                              resp_valid;
  logic [TAG_W-1:0]                  resp_tag;
  logic [IDX_W-1:0]                  resp_index;

  int                                checks;
  int                                errors;
  logic [PC_W-1:0]                   resident [$];

  assign resp_valid = model_valid | spur_valid;
  assign resp_tag   = spur_valid ? spur_tag : model_tag;
  assign resp_index = spur_valid ? spur_index : model_index;

  icache_top u_icache_top (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req),
    .pc_i             (pc),
    .inst_o           (inst),
    .inst_valid_o     (inst_valid),
    .ic_miss_o        (ic_miss),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_addr_o   (mem_req_addr),
    .mem_resp_valid_i (resp_valid),
    .mem_resp_tag_i   (resp_tag),
    .mem_resp_index_i (resp_index),
    .mem_resp_data_i  (model_data),
    .flush_i          (flush),
    .flush_done_o     (flush_done)
  );

  icache_mem_model #(
    .NUM_SETS  (NUM_SETS),
    .MIN_DELAY (2),
    .MAX_DELAY (MAX_DELAY)
  ) u_mem_model (
    .clk          (clk),
    .reset        (reset),
    .req_valid_i  (mem_req_valid),
    .req_addr_i   (mem_req_addr),
    .resp_valid_o (model_valid),
    .resp_tag_o   (model_tag),
    .resp_index_o (model_index),
    .resp_data_o  (model_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // run limit
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog: tests did not finish within %0d cycles (%0d errors so far)",
             WATCHDOG_CYCLES, errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input bit cond, input string msg);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("FAIL %0t: %s", $time, msg);
    end
  endtask

  function automatic logic [PC_W-1:0] make_pc(input logic [31:0] tag, input int idx,
                                               input int off);
    return {tag[TAG_W-1:0], IDX_W'(idx), OFFSET_W'(off), {INST_BYTES_LOG{1'b0}}};
  endfunction

  // tag and index, as carried on the memory side
  function automatic logic [TAG_W+IDX_W-1:0] line_addr(input logic [PC_W-1:0] addr);
    return addr[PC_W-1 -: TAG_W+IDX_W];
  endfunction

  function automatic bit resp_for(input logic [PC_W-1:0] addr);
    return resp_valid && ({resp_tag, resp_index} == line_addr(addr));
  endfunction

  // slot k holds pc + 4k up to the line end, then goes invalid
  task automatic check_slots(input logic [PC_W-1:0] addr);
    int off;
    bit exp_valid;
    off = int'(addr[INST_BYTES_LOG +: OFFSET_W]);
    for (int k = 0; k < FETCH_WIDTH; k++)
    begin
      exp_valid = (off + k) < INSTS_PER_LINE;
      check(inst_valid[k] == exp_valid,
            $sformatf("pc %h slot %0d valid %b, expected %b", addr, k, inst_valid[k], exp_valid));
      if (exp_valid)
      begin
        check(inst[k] == addr + PC_W'(4 * k),
              $sformatf("pc %h slot %0d is %h, expected %h", addr, k, inst[k], addr + 4 * k));
      end
    end
  endtask

  // one cycle of fetch, sampled mid-cycle
  task automatic fetch_and_check(input logic [PC_W-1:0] addr, input bit want_hit);
    @(posedge clk);
    fetch_req <= 1'b1;
    pc        <= addr;
    @(negedge clk);
    check(inst_valid[0] == want_hit,
          $sformatf("pc %h hit %b, expected %b", addr, inst_valid[0], want_hit));
    if (want_hit)
    begin
      check_slots(addr);
    end
  endtask

  task automatic sweep_line(input logic [PC_W-1:0] addr);
    logic [PC_W-1:0] base;
    base = {addr[PC_W-1:IDX_LSB], {IDX_LSB{1'b0}}};
    for (int o = 0; o < INSTS_PER_LINE; o++)
    begin
      fetch_and_check(base + PC_W'(4 * o), 1'b1);
    end
  endtask

  // cold miss, one request next cycle, hit two cycles after the answer
  task automatic miss_and_fill(input logic [PC_W-1:0] addr);
    int  reqs;
    int  waited;
    bit  got;
    reqs   = 0;
    waited = 0;
    got    = 0;
    @(posedge clk);
    fetch_req <= 1'b1;
    pc        <= addr;
    @(negedge clk);
    check(!inst_valid[0], $sformatf("pc %h hit before any fill", addr));
    check(!mem_req_valid, $sformatf("request in the miss cycle of pc %h", addr));
    while (!got && waited < 3 * MAX_DELAY)
    begin
      @(negedge clk);
      waited++;
      if (waited == 1)
      begin
        check(mem_req_valid && ic_miss && mem_req_addr == line_addr(addr),
              $sformatf("request %b addr %h, expected line %h", mem_req_valid, mem_req_addr,
                        line_addr(addr)));
      end
      if (mem_req_valid)
      begin
        reqs++;
      end
      got = resp_for(addr);
    end
    if (!got)
    begin
      errors++;
      $display("memory never answered the read of line %h", line_addr(addr));
    end
    else
    begin
      check(reqs == 1, $sformatf("%0d requests for line %h", reqs, line_addr(addr)));
      @(negedge clk);
      check(!inst_valid[0], $sformatf("pc %h hit in the fill cycle", addr));
      check(!mem_req_valid, $sformatf("request in the fill cycle of pc %h", addr));
      @(negedge clk);
      check(inst_valid[0], $sformatf("pc %h missed after its fill", addr));
      check_slots(addr);
    end
  endtask

  // no fetch, wait out any read still in flight
  task automatic go_idle();
    @(posedge clk);
    fetch_req <= 1'b0;
    repeat (MAX_DELAY + 4) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic check_quiet(input string when);
    check(!mem_req_valid && !ic_miss && !flush_done,
          $sformatf("control outputs active %s", when));
    check(inst_valid == '0, $sformatf("fetch hit %s", when));
  endtask

  // fetch held high with no valid line
  task automatic reset_test();
    repeat (4)
    begin
      @(negedge clk);
      check_quiet("during reset");
    end
    @(posedge clk);
    reset     <= 1'b0;
    fetch_req <= 1'b0;
    repeat (2)
    begin
      @(negedge clk);
      check_quiet("after reset");
    end
  endtask

  // second miss waits for the first fill, wrong tag never fills
  task automatic pending_miss_test(input logic [PC_W-1:0] pc_a, input logic [PC_W-1:0] pc_b);
    bit a_seen;
    bit b_seen;
    int reqs_b;
    int req_b_cyc;
    int cyc;
    a_seen    = 0;
    b_seen    = 0;
    reqs_b    = 0;
    req_b_cyc = -1;
    cyc       = 0;
    @(posedge clk);
    fetch_req <= 1'b1;
    pc        <= pc_a;
    while (!b_seen && cyc < 60)
    begin
      @(negedge clk);
      if (cyc == 1)
      begin
        check(mem_req_valid && mem_req_addr == line_addr(pc_a),
              $sformatf("no request for line %h", line_addr(pc_a)));
      end
      else if (mem_req_valid)
      begin
        check(a_seen && mem_req_addr == line_addr(pc_b),
              $sformatf("request %h while line %h pending", mem_req_addr, line_addr(pc_a)));
        reqs_b++;
        if (req_b_cyc < 0)
        begin
          req_b_cyc = cyc;
        end
      end
      // a wrong-tag answer two cycles back would show as a hit here
      if (req_b_cyc >= 0 && cyc == req_b_cyc + 3)
      begin
        check(!inst_valid[0], $sformatf("pc %h hit after a wrong-tag response", pc_b));
      end
      a_seen = a_seen | resp_for(pc_a);
      b_seen = resp_for(pc_b);
      @(posedge clk);
      // wrong tag for line b, one cycle after its request
      spur_valid <= (req_b_cyc >= 0 && cyc == req_b_cyc);
      spur_tag   <= pc_b[PC_W-1 -: TAG_W] ^ TAG_W'(1);
      spur_index <= pc_b[IDX_LSB +: IDX_W];
      // line a is still in flight when fetch moves on to line b
      if (cyc == 1)
      begin
        pc <= pc_b;
      end
      cyc++;
    end
    if (!b_seen)
    begin
      errors++;
      $display("memory never answered the read of line %h", line_addr(pc_b));
    end
    else
    begin
      @(negedge clk);
      check(!inst_valid[0], $sformatf("pc %h hit in the fill cycle", pc_b));
      @(negedge clk);
      check(inst_valid[0], $sformatf("pc %h missed after its fill", pc_b));
      check_slots(pc_b);
      check(reqs_b == 1, $sformatf("%0d requests for line %h", reqs_b, line_addr(pc_b)));
      fetch_and_check(pc_a, 1'b1);
    end
  endtask

  // five tags in one set, round robin drops the first one
  task automatic eviction_test(input int set_idx);
    logic [PC_W-1:0] tpc [5];
    logic [31:0]     tag_base;
    tag_base = $urandom;
    for (int i = 0; i < 5; i++)
    begin
      tpc[i] = make_pc(tag_base + i, set_idx, $urandom_range(7, 0));
    end
    for (int i = 0; i < 4; i++)
    begin
      miss_and_fill(tpc[i]);
    end
    for (int i = 0; i < 4; i++)
    begin
      fetch_and_check(tpc[i], 1'b1);
    end
    miss_and_fill(tpc[4]);
    for (int i = 1; i < 5; i++)
    begin
      fetch_and_check(tpc[i], 1'b1);
    end
    // refilling the first tag in turn pushes out the second
    miss_and_fill(tpc[0]);
    resident.push_back(tpc[0]);
    for (int i = 2; i < 5; i++)
    begin
      resident.push_back(tpc[i]);
    end
  endtask

  task automatic flush_test();
    foreach (resident[i])
    begin
      fetch_and_check(resident[i], 1'b1);
    end
    @(posedge clk);
    fetch_req <= 1'b0;
    flush     <= 1'b1;
    @(negedge clk);
    check(!flush_done, "flush done in the flush cycle");
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check(flush_done, "flush done missing one cycle after flush");
    @(negedge clk);
    check(!flush_done, "flush done held longer than one cycle");
    foreach (resident[i])
    begin
      fetch_and_check(resident[i], 1'b0);
    end
    go_idle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [PC_W-1:0] addr;
    logic [PC_W-1:0] pc_a;
    logic [PC_W-1:0] pc_b;
    void'($urandom(91));
    checks     = 0;
    errors     = 0;
    reset      = 1'b1;
    fetch_req  = 1'b1;
    pc         = '0;
    flush      = 1'b0;
    spur_valid = 1'b0;
    spur_tag   = '0;
    spur_index = '0;

    reset_test();

    // sets 0 to 5 each take one line, so nothing is evicted early
    for (int idx = 0; idx < 4; idx++)
    begin
      addr = make_pc($urandom, idx, $urandom_range(7, 0));
      miss_and_fill(addr);
      sweep_line(addr);
      resident.push_back(addr);
    end

    pc_a = make_pc($urandom, 4, $urandom_range(7, 0));
    pc_b = make_pc($urandom, 5, $urandom_range(7, 0));
    pending_miss_test(pc_a, pc_b);
    resident.push_back(pc_a);
    resident.push_back(pc_b);

    eviction_test($urandom_range(NUM_SETS - 1, NUM_SETS / 2));
    flush_test();

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/icache_mem_model.sv
/*
  line memory for the instruction cache testbench
  answers each line read after a random delay
  the word at byte address A holds the value A
*/

module icache_mem_model
  import icache_pkg::*;
#(
  parameter int  NUM_SETS  = 32,
  parameter int  MIN_DELAY = 2,
  parameter int  MAX_DELAY = 9,
  localparam int IDX_W     = $clog2(NUM_SETS),
  localparam int TAG_W     = PC_W - IDX_W - OFFSET_W - INST_BYTES_LOG
)
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid_i,
  input  logic [TAG_W+IDX_W-1:0] req_addr_i,
  output logic                   resp_valid_o,
  output logic [TAG_W-1:0]       resp_tag_o,
  output logic [IDX_W-1:0]       resp_index_o,
  output line_u                  resp_data_o
);

  // pending reads in arrival order, with the cycle each one answers in
  logic [TAG_W+IDX_W-1:0] addr_q [$];
  int unsigned            due_q  [$];
  int unsigned            cycle;
  int unsigned            last_due;
  int unsigned            due;
  logic [TAG_W+IDX_W-1:0] addr;

  // every word is its own byte address, so any line can be checked
  function automatic line_u line_for(input logic [TAG_W+IDX_W-1:0] line_addr);
    line_u line;
    for (int k = 0; k < INSTS_PER_LINE; k++)
    begin
      line.insts[k] = {line_addr, OFFSET_W'(k), {INST_BYTES_LOG{1'b0}}};
    end
    return line;
  endfunction

  always @(posedge clk)
  begin
    if (reset)
    begin
      addr_q.delete();
      due_q.delete();
      cycle        <= 0;
      last_due     = 0;
      resp_valid_o <= 1'b0;
      resp_tag_o   <= '0;
      resp_index_o <= '0;
      resp_data_o  <= '0;
    end
    else
    begin
      resp_valid_o <= 1'b0;
      // answers stay in order, at most one per cycle
      if (req_valid_i)
      begin
        due = cycle + $urandom_range(MAX_DELAY, MIN_DELAY);
        if (due <= last_due)
        begin
          due = last_due + 1;
        end
        last_due = due;
        addr_q.push_back(req_addr_i);
        due_q.push_back(due);
      end
      // driven here, seen by the cache in the due cycle
      if (due_q.size() > 0 && due_q[0] == cycle + 1)
      begin
        addr = addr_q.pop_front();
        void'(due_q.pop_front());
        resp_valid_o <= 1'b1;
        resp_tag_o   <= addr[TAG_W+IDX_W-1 -: TAG_W];
        resp_index_o <= addr[IDX_W-1:0];
        resp_data_o  <= line_for(addr);
      end
      cycle <= cycle + 1;
    end
  end

endmodule

// File: rtl/icache_top.sv
/*
  instruction cache top level
  way array for storage and hit detection
  single MSHR for miss tracking and line fill
  fetch aligner for the instruction slots
*/

module icache_top
  import icache_pkg::*;
#(
  parameter int  NUM_WAYS    = 4,
  parameter int  NUM_SETS    = 32,
  parameter int  FETCH_WIDTH = 4,
  localparam int IDX_W       = $clog2(NUM_SETS),
  localparam int TAG_W       = PC_W - IDX_W - OFFSET_W - INST_BYTES_LOG,
  localparam int WAY_W       = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
)
(
  input  logic                              clk,
  input  logic                              reset,

  // fetch side
  input  logic                              fetch_req_i,
  input  logic [PC_W-1:0]                   pc_i,
  output logic [FETCH_WIDTH-1:0][INST_W-1:0] inst_o,
  output logic [FETCH_WIDTH-1:0]            inst_valid_o,
  output logic                              ic_miss_o,

  // memory request
  output logic                              mem_req_valid_o,
  output logic [TAG_W+IDX_W-1:0]            mem_req_addr_o,

  // memory response
  input  logic                              mem_resp_valid_i,
  input  logic [TAG_W-1:0]                  mem_resp_tag_i,
  input  logic [IDX_W-1:0]                  mem_resp_index_i,
  input  line_u                             mem_resp_data_i,

  // flush
  input  logic                              flush_i,
  output logic                              flush_done_o
);

  // lookup results
  logic [NUM_WAYS-1:0] way_hit;
  line_u [NUM_WAYS-1:0] way_line;
  logic                hit;

  // fill path from the MSHR back into the array
  logic                fill_valid;
  logic [WAY_W-1:0]    fill_way;
  logic [IDX_W-1:0]    fill_index;
  logic [TAG_W-1:0]    fill_tag;
  line_u               fill_line;

  // storage, tag compare, flush
  icache_way_array #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) u_way_array (
    .clk          (clk),
    .reset        (reset),
    .fetch_req_i  (fetch_req_i),
    .pc_i         (pc_i),
    .fill_valid_i (fill_valid),
    .fill_way_i   (fill_way),
    .fill_index_i (fill_index),
    .fill_tag_i   (fill_tag),
    .fill_line_i  (fill_line),
    .flush_i      (flush_i),
    .way_hit_o    (way_hit),
    .way_line_o   (way_line),
    .hit_o        (hit),
    .flush_done_o (flush_done_o)
  );

  // miss request, response match, victim choice
  icache_mshr #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) u_mshr (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req_i),
    .pc_i             (pc_i),
    .hit_i            (hit),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .ic_miss_o        (ic_miss_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_tag_i   (mem_resp_tag_i),
    .mem_resp_index_i (mem_resp_index_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .fill_valid_o     (fill_valid),
    .fill_way_o       (fill_way),
    .fill_index_o     (fill_index),
    .fill_tag_o       (fill_tag),
    .fill_line_o      (fill_line)
  );

  // instruction slots from the hitting way
  icache_fetch_align #(
    .NUM_WAYS    (NUM_WAYS),
    .FETCH_WIDTH (FETCH_WIDTH)
  ) u_fetch_align (
    .pc_i         (pc_i),
    .way_hit_i    (way_hit),
    .way_line_i   (way_line),
    .inst_o       (inst_o),
    .inst_valid_o (inst_valid_o)
  );

endmodule

// File: rtl/icache_miss/icache_mshr.sv
/*
  miss handling for the instruction cache
  miss pulse, single MSHR and memory request
  response match, fill registers, per-set round-robin victim
*/

module icache_mshr
  import icache_pkg::*;
#(
  parameter int  NUM_WAYS = 4,
  parameter int  NUM_SETS = 32,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = PC_W - IDX_W - OFFSET_W - INST_BYTES_LOG,
  localparam int WAY_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
)
(
  input  logic                   clk,
  input  logic                   reset,

  // lookup side
  input  logic                   fetch_req_i,
  input  logic [PC_W-1:0]        pc_i,
  input  logic                   hit_i,

  // memory request
  output logic                   mem_req_valid_o,
  output logic [TAG_W+IDX_W-1:0] mem_req_addr_o,
  output logic                   ic_miss_o,

  // memory response
  input  logic                   mem_resp_valid_i,
  input  logic [TAG_W-1:0]       mem_resp_tag_i,
  input  logic [IDX_W-1:0]       mem_resp_index_i,
  input  line_u                  mem_resp_data_i,

  // fill into the way array
  output logic                   fill_valid_o,
  output logic [WAY_W-1:0]       fill_way_o,
  output logic [IDX_W-1:0]       fill_index_o,
  output logic [TAG_W-1:0]       fill_tag_o,
  output line_u                  fill_line_o
);

  localparam int IDX_LSB = OFFSET_W + INST_BYTES_LOG;

  // fetch address, one cycle late for the request
  logic [TAG_W-1:0] pc_tag_q;
  logic [IDX_W-1:0] pc_index_q;

  // miss edge detect
  logic             miss;
  logic             miss_d1;
  logic             miss_d2;
  logic             miss_pulse;
  logic             req_fire;

  // the single MSHR entry
  logic             mshr_valid_q;
  logic [TAG_W-1:0] mshr_tag_q;
  logic [IDX_W-1:0] mshr_index_q;
  logic             resp_match;

  // round-robin victim, one pointer per set
  logic [WAY_W-1:0] victim_q [NUM_SETS];

  always_ff @(posedge clk)
  begin
    pc_tag_q   <= pc_i[PC_W-1 -: TAG_W];
    pc_index_q <= pc_i[IDX_LSB +: IDX_W];
  end

  //////////////////////////////////////////////////////////////////////
  // miss pulse and request
  //////////////////////////////////////////////////////////////////////

  assign miss = fetch_req_i & ~hit_i;

  // a held miss gives one pulse
  // a fill clears both flags so a miss still waiting pulses again
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      miss_d1 <= miss & ~fill_valid_o;
      miss_d2 <= miss_d1 & ~fill_valid_o;
    end
  end

  assign miss_pulse = miss_d1 & ~miss_d2;

  // request only when the MSHR is free or being freed by a fill now
  // otherwise fetch keeps replaying and the pulse comes back after the fill
  assign req_fire        = miss_pulse & (~mshr_valid_q | fill_valid_o);
  assign mem_req_valid_o = req_fire;
  assign mem_req_addr_o  = {pc_tag_q, pc_index_q};
  assign ic_miss_o       = req_fire;

  //////////////////////////////////////////////////////////////////////
  // MSHR entry
  //////////////////////////////////////////////////////////////////////

  // a new request takes the entry, even in the cycle a fill frees it
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mshr_valid_q <= 1'b0;
    end
    else if (req_fire)
    begin
      mshr_valid_q <= 1'b1;
    end
    else if (fill_valid_o)
    begin
      mshr_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      mshr_tag_q   <= pc_tag_q;
      mshr_index_q <= pc_index_q;
    end
  end

  // responses for other lines go past untouched
  assign resp_match = mem_resp_valid_i & mshr_valid_q &
                      (mem_resp_tag_i == mshr_tag_q) &
                      (mem_resp_index_i == mshr_index_q);

  //////////////////////////////////////////////////////////////////////
  // fill registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fill_valid_o <= 1'b0;
    end
    else
    begin
      fill_valid_o <= resp_match;
    end
  end

  // line payload held for the write cycle
  always_ff @(posedge clk)
  begin
    if (resp_match)
    begin
      fill_tag_o   <= mshr_tag_q;
      fill_index_o <= mshr_index_q;
      fill_line_o  <= mem_resp_data_i;
    end
  end

  // victim pointer steps past the way just written
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < NUM_SETS; s++)
      begin
        victim_q[s] <= '0;
      end
    end
    else if (fill_valid_o)
    begin
      if (victim_q[fill_index_o] == WAY_W'(NUM_WAYS - 1))
      begin
        victim_q[fill_index_o] <= '0;
      end
      else
      begin
        victim_q[fill_index_o] <= victim_q[fill_index_o] + 1'b1;
      end
    end
  end

  assign fill_way_o = victim_q[fill_index_o];

endmodule

// File: rtl/icache_lookup/icache_fetch_align.sv
/*
  fetch aligner
  picks the line of the lowest hitting way
  cuts instruction slots from the pc offset onward
*/

module icache_fetch_align
  import icache_pkg::*;
#(
  parameter int NUM_WAYS    = 4,
  parameter int FETCH_WIDTH = 4
)
(
  input  logic [PC_W-1:0]                    pc_i,
  input  logic [NUM_WAYS-1:0]                way_hit_i,
  input  line_u [NUM_WAYS-1:0]               way_line_i,
  output logic [FETCH_WIDTH-1:0][INST_W-1:0] inst_o,
  output logic [FETCH_WIDTH-1:0]             inst_valid_o
);

  // first instruction of the fetch group inside the line
  logic [OFFSET_W-1:0] pc_offset;

  // line of the hitting way
  line_u               sel_line;
  logic                any_hit;

  assign pc_offset = pc_i[INST_BYTES_LOG +: OFFSET_W];
  assign any_hit   = |way_hit_i;

  // way select
  // walk downward so the lowest hitting way is the one kept
  always_comb
  begin
    sel_line = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
    begin
      if (way_hit_i[w])
      begin
        sel_line = way_line_i[w];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // slot extraction
  //////////////////////////////////////////////////////////////////////

  // slot k reads the word at offset plus k
  // slots past the end of the line stay invalid and zero,
  // the next group starts in the following line
  always_comb
  begin
    logic [OFFSET_W:0] slot_pos;
    for (int k = 0; k < FETCH_WIDTH; k++)
    begin
      // one extra bit so the line end is seen and not wrapped
      slot_pos        = {1'b0, pc_offset} + (OFFSET_W + 1)'(k);
      inst_valid_o[k] = any_hit & (slot_pos < (OFFSET_W + 1)'(INSTS_PER_LINE));
      if (inst_valid_o[k])
      begin
        inst_o[k] = sel_line.insts[slot_pos[OFFSET_W-1:0]];
      end
      else
      begin
        inst_o[k] = '0;
      end
    end
  end

endmodule

// File: rtl/icache_lookup/icache_way_array.sv
/*
  tag, valid and data arrays for every way and set
  asynchronous read at the fetch index with per-way hit
  line fill into one way, full flush with done flag
*/

module icache_way_array
  import icache_pkg::*;
#(
  parameter int  NUM_WAYS = 4,
  parameter int  NUM_SETS = 32,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = PC_W - IDX_W - OFFSET_W - INST_BYTES_LOG,
  localparam int WAY_W    = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
)
(
  input  logic                 clk,
  input  logic                 reset,

  // lookup
  input  logic                 fetch_req_i,
  input  logic [PC_W-1:0]      pc_i,

  // fill from the MSHR
  input  logic                 fill_valid_i,
  input  logic [WAY_W-1:0]     fill_way_i,
  input  logic [IDX_W-1:0]     fill_index_i,
  input  logic [TAG_W-1:0]     fill_tag_i,
  input  line_u                fill_line_i,

  // flush
  input  logic                 flush_i,

  // lookup results
  output logic [NUM_WAYS-1:0]  way_hit_o,
  output line_u [NUM_WAYS-1:0] way_line_o,
  output logic                 hit_o,
  output logic                 flush_done_o
);

  // lowest pc bit of the index field
  localparam int IDX_LSB = OFFSET_W + INST_BYTES_LOG;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  logic [TAG_W-1:0]    tag_q   [NUM_WAYS][NUM_SETS];
  line_u               data_q  [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];

  // fetch pc fields
  logic [IDX_W-1:0]    pc_index;
  logic [TAG_W-1:0]    pc_tag;

  assign pc_index = pc_i[IDX_LSB +: IDX_W];
  assign pc_tag   = pc_i[PC_W-1 -: TAG_W];

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////

  // every way is read at the same index in the fetch cycle
  // a hit needs a request, a valid entry and a tag match
  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      way_line_o[w] = data_q[w][pc_index];
      way_hit_o[w]  = fetch_req_i & valid_q[w][pc_index] &
                      (tag_q[w][pc_index] == pc_tag);
    end
  end

  // combined hit, tells the MSHR there is nothing to fetch
  assign hit_o = |way_hit_o;

  //////////////////////////////////////////////////////////////////////
  // fill and flush
  //////////////////////////////////////////////////////////////////////

  // line and tag land in the victim way picked by the MSHR
  always_ff @(posedge clk)
  begin
    if (fill_valid_i)
    begin
      data_q[fill_way_i][fill_index_i] <= fill_line_i;
      tag_q[fill_way_i][fill_index_i]  <= fill_tag_i;
    end
  end

  // valid bits
  // flush wipes every way and wins over a fill in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        valid_q[w] <= '0;
      end
    end
    else if (flush_i)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        valid_q[w] <= '0;
      end
    end
    else if (fill_valid_i)
    begin
      valid_q[fill_way_i][fill_index_i] <= 1'b1;
    end
  end

  // done one cycle after the flush request, valid bits already clear
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      flush_done_o <= 1'b0;
    end
    else
    begin
      flush_done_o <= flush_i;
    end
  end

endmodule

// File: common/icache_pkg.sv
/*
  shared widths for the instruction cache
  fetch address and instruction sizes, line geometry
  cache line union with raw and per-instruction views
*/

package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // address and instruction geometry
  //////////////////////////////////////////////////////////////////////

  // fetch address width
  localparam int PC_W = 32;

  // one instruction word
  localparam int INST_W = 32;

  // pc bits below the instruction offset, word aligned fetch
  localparam int INST_BYTES_LOG = 2;

  //////////////////////////////////////////////////////////////////////
  // line geometry
  //////////////////////////////////////////////////////////////////////

  // instructions held by one cache line
  localparam int INSTS_PER_LINE = 8;

  // bits in a full line
  localparam int LINE_W = INSTS_PER_LINE * INST_W;

  // instruction offset field inside the pc
  localparam int OFFSET_W = $clog2(INSTS_PER_LINE);

  // pc layout, msb to lsb
  //   tag | index | offset | byte
  // index and tag widths depend on the set count
  // and are worked out by each module

  //////////////////////////////////////////////////////////////////////
  // cache line
  //////////////////////////////////////////////////////////////////////

  // memory delivers a flat vector and the array stores it as is
  // the aligner picks instruction slots out of the same bits
  // slot 0 sits in the low bits, so it holds the lowest address
  typedef union packed {
    logic [LINE_W-1:0]                     raw;
    logic [INSTS_PER_LINE-1:0][INST_W-1:0] insts;
  } line_u;

endpackage
